/* verilog/alloc_config.svh */
// sizing of the cell store and the self-test script
// the cell range must stay clear of the reserved low addresses (UNDEF)
`ifndef ALLOC_CONFIG_SVH
`define ALLOC_CONFIG_SVH

`define CELL_BASE    16'h5000  // address of cell 0
`define CELL_COUNT   256       // cells in the store, one word each
`define SCRIPT_STEPS 32        // self-test ROM depth
`define DEBUG_W      64        // width of the o_debug record

`endif

/* verilog/cellPkg.sv */
// cell word and address types, shared by the allocator and the store
// addresses outside the cell range map to a wrapped index
`default_nettype none

package cellPkg;
`include "alloc_config.svh"

    typedef logic [15:0] cellWord_t;  // one data word
    typedef logic [15:0] cellAddr_t;  // full cell address
    typedef logic [7:0]  cellIdx_t;   // index into the store

    localparam cellWord_t UNDEF = 16'h0000;  // returned when every cell is in use

    function automatic cellIdx_t toIdx(cellAddr_t addr);
        return cellIdx_t'(addr - `CELL_BASE);  // drop the base
    endfunction

    function automatic logic inRange(cellAddr_t addr);
        return (addr >= `CELL_BASE) && (addr < `CELL_BASE + `CELL_COUNT);
    endfunction

endpackage

`default_nettype wire

/* verilog/testPkg.sv */
// self-test types for the FSM states, one ROM step and the debug record
// a step's compare flags check the previous step's response
`default_nettype none

package testPkg;

    typedef enum logic [1:0] {
        RUN,   // script stepping
        FAIL,  // compare mismatch, o_debug latched
        PASS   // last step reached cleanly
    } testState_t;

    typedef logic [4:0] stepIdx_t;  // script position

    typedef struct packed {
        logic               al;     // alloc strobe
        cellPkg::cellWord_t adata;
        logic               acmp;   // check previous alloc result
        cellPkg::cellAddr_t axpct;
        logic               fr;     // free strobe
        cellPkg::cellAddr_t faddr;
        logic               wr;     // user write strobe
        cellPkg::cellAddr_t waddr;
        cellPkg::cellWord_t wdata;
        logic               rd;     // read strobe
        cellPkg::cellAddr_t raddr;
        logic               rcmp;   // check previous read result
        cellPkg::cellWord_t rxpct;
        logic               last;   // final step of the script
    } scriptStep_t;

    typedef struct packed {
        cellPkg::cellWord_t failStep;  // step index, zero-extended
        cellPkg::cellWord_t expVal;
        cellPkg::cellWord_t actVal;
        cellPkg::cellAddr_t lastAddr;  // last alloc address seen
    } testDebug_t;

endpackage

`default_nettype wire

/* verilog/cellBus.sv */
// request and response signals of the cell bus
// strobes are single-cycle, with no handshake and no back-pressure
`timescale 1ns/1ps
`default_nettype none

interface cellBus;
    import cellPkg::*;

    logic      al;     // alloc strobe
    cellWord_t adata;  // word placed in the new cell
    cellAddr_t aaddr;  // granted address, registered
    logic      fr;     // free strobe
    cellAddr_t faddr;
    logic      wr;     // user write
    cellAddr_t waddr;
    cellWord_t wdata;
    logic      rd;     // user read
    cellAddr_t raddr;
    cellWord_t rdata;  // registered read data

    modport requester (
        output al, adata, fr, faddr, wr, waddr, wdata, rd, raddr,
        input  aaddr, rdata
    );

    modport allocator (
        input  al, adata, fr, faddr,
        output aaddr
    );

    modport storage (
        input  wr, waddr, wdata, rd, raddr,
        output rdata
    );

endinterface

`default_nettype wire

/* verilog/allocSelfTest.sv */
// built-in self-test, one script step per cycle while i_en is high
// owns the cell bus while running; external requests are ignored until it stops
// the script assumes a freshly reset allocator and store
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module allocSelfTest (
    input  wire logic               i_clk,
    input  wire logic               i_arstN,
    input  wire logic               i_en,      // pauses the script when low
    input  wire logic               i_al,
    input  wire cellPkg::cellWord_t i_adata,
    input  wire logic               i_fr,
    input  wire cellPkg::cellAddr_t i_faddr,
    input  wire logic               i_wr,
    input  wire cellPkg::cellAddr_t i_waddr,
    input  wire cellPkg::cellWord_t i_wdata,
    input  wire logic               i_rd,
    input  wire cellPkg::cellAddr_t i_raddr,
    output logic                    o_running,
    output logic                    o_passed,
    output testPkg::testDebug_t     o_debug,
    cellBus.requester               bus
);
    import cellPkg::*;
    import testPkg::*;

    testState_t  state;
    stepIdx_t    step;
    scriptStep_t rom [`SCRIPT_STEPS];
    scriptStep_t cur;                 // step being executed
    logic        aFail;
    logic        rFail;

    always_comb begin
        rom = '{default: '0};  // unused entries are no-ops, step 0 too
        rom[1]  = '{wr: 1'b1, waddr: 16'h50FF, wdata: 16'hBE11, default: '0};
        rom[2]  = '{wr: 1'b1, waddr: 16'h5095, wdata: 16'hC0DE, default: '0};
        rom[3]  = '{rd: 1'b1, raddr: 16'h50FF, default: '0};
        rom[4]  = '{rd: 1'b1, raddr: 16'h5095, rcmp: 1'b1, rxpct: 16'hBE11, default: '0};
        rom[5]  = '{rcmp: 1'b1, rxpct: 16'hC0DE, default: '0};
        rom[6]  = '{rd: 1'b1, raddr: 16'h50FF,
                    wr: 1'b1, waddr: 16'h5034, wdata: 16'hD05E, default: '0};
        rom[7]  = '{rcmp: 1'b1, rxpct: 16'hBE11, default: '0};
        rom[8]  = '{rd: 1'b1, raddr: 16'h5034,  // same-cell collision
                    wr: 1'b1, waddr: 16'h5034, wdata: 16'hEA5E, default: '0};
        rom[9]  = '{rcmp: 1'b1, rxpct: 16'hD05E, default: '0};  // old value
        rom[10] = '{rd: 1'b1, raddr: 16'h5034, default: '0};
        rom[11] = '{rcmp: 1'b1, rxpct: 16'hEA5E, default: '0};
        rom[12] = '{al: 1'b1, adata: 16'hFADE, default: '0};  // fresh cells
        rom[13] = '{al: 1'b1, adata: 16'hAB1E, acmp: 1'b1, axpct: 16'h5000, default: '0};
        rom[14] = '{al: 1'b1, adata: 16'hB055, acmp: 1'b1, axpct: 16'h5001, default: '0};
        rom[15] = '{acmp: 1'b1, axpct: 16'h5002, default: '0};
        rom[16] = '{al: 1'b1, adata: 16'hCE11,  // freed cell handed straight over
                    fr: 1'b1, faddr: 16'h5001, default: '0};
        rom[17] = '{fr: 1'b1, faddr: 16'h5002, acmp: 1'b1, axpct: 16'h5001, default: '0};
        rom[18] = '{fr: 1'b1, faddr: 16'h5001, default: '0};
        rom[19] = '{al: 1'b1, adata: 16'hDEAF, default: '0};  // LIFO reuse
        rom[20] = '{al: 1'b1, adata: 16'hE15E, acmp: 1'b1, axpct: 16'h5001, default: '0};
        rom[21] = '{al: 1'b1, adata: 16'hF001, acmp: 1'b1, axpct: 16'h5002, default: '0};
        rom[22] = '{acmp: 1'b1, axpct: 16'h5003, default: '0};  // list empty, fresh again
        rom[23] = '{rd: 1'b1, raddr: 16'h5001, default: '0};
        rom[24] = '{rcmp: 1'b1, rxpct: 16'hDEAF, last: 1'b1, default: '0};
    end

    assign cur       = rom[step];
    assign o_running = i_en && (state == RUN);

    assign aFail = cur.acmp && (bus.aaddr != cur.axpct);
    assign rFail = cur.rcmp && (bus.rdata != cur.rxpct);

    always_comb begin
        bus.al    = o_running ? cur.al    : i_al;  // script owns the bus while running
        bus.adata = o_running ? cur.adata : i_adata;
        bus.fr    = o_running ? cur.fr    : i_fr;
        bus.faddr = o_running ? cur.faddr : i_faddr;
        bus.wr    = o_running ? cur.wr    : i_wr;
        bus.waddr = o_running ? cur.waddr : i_waddr;
        bus.wdata = o_running ? cur.wdata : i_wdata;
        bus.rd    = o_running ? cur.rd    : i_rd;
        bus.raddr = o_running ? cur.raddr : i_raddr;
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state    <= RUN;
            step     <= '0;
            o_passed <= 1'b0;
            o_debug  <= '0;
        end else if (o_running) begin
            step <= step + 1'b1;
            if (aFail || rFail) begin
                state            <= FAIL;
                o_debug.failStep <= cellWord_t'(step);
                o_debug.expVal   <= aFail ? cur.axpct : cur.rxpct;  // alloc check first
                o_debug.actVal   <= aFail ? bus.aaddr : bus.rdata;
                o_debug.lastAddr <= bus.aaddr;
            end else if (cur.last) begin
                state    <= PASS;
                o_passed <= 1'b1;
            end
        end
    end

    // a finished run stays finished until the next reset
    aDoneSticky: assert property (@(posedge i_clk) disable iff (!i_arstN)
        (state != RUN) |=> (state == $past(state)));

    // never free the cell just handed out while allocating again
    aNoSameCell: assert property (@(posedge i_clk) disable iff (!i_arstN)
        (o_running && cur.al && cur.fr) |-> (cur.faddr != bus.aaddr));

endmodule

`default_nettype wire

/* verilog/allocFreeList.sv */
// free-list allocator picking a same-cycle free first, then the LIFO head, then the fresh counter
// no double-free detection; freeing a live cell twice corrupts the list
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module allocFreeList (
    input  wire logic          i_clk,
    input  wire logic          i_arstN,
    cellBus.allocator          bus,
    output logic               o_allocWr,    // store the alloc word this edge
    output cellPkg::cellIdx_t  o_allocIdx,
    output cellPkg::cellWord_t o_allocData
);
    import cellPkg::*;

    cellAddr_t                   head;                  // UNDEF when the list is empty
    cellAddr_t                   link [`CELL_COUNT];    // next pointer per freed cell
    logic [$clog2(`CELL_COUNT):0] freshCnt;             // cells never handed out start here
    cellAddr_t                   grant;
    logic                        popHead;
    logic                        useFresh;

    always_comb begin
        grant    = UNDEF;
        popHead  = 1'b0;
        useFresh = 1'b0;
        if (bus.fr) begin
            grant = bus.faddr;  // bypass, list untouched
        end else if (head != UNDEF) begin
            grant   = head;
            popHead = 1'b1;
        end else if (freshCnt < `CELL_COUNT) begin
            grant    = cellAddr_t'(`CELL_BASE + freshCnt);
            useFresh = 1'b1;
        end
    end

    assign o_allocWr   = bus.al && (grant != UNDEF);  // full store writes nothing
    assign o_allocIdx  = toIdx(grant);
    assign o_allocData = bus.adata;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            head      <= UNDEF;
            freshCnt  <= '0;
            bus.aaddr <= UNDEF;
        end else if (bus.al) begin
            bus.aaddr <= grant;  // held until the next alloc
            if (popHead) begin
                head <= link[toIdx(head)];
            end
            if (useFresh) begin
                freshCnt <= freshCnt + 1'b1;
            end
        end else if (bus.fr) begin
            head <= bus.faddr;  // push
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.fr && !bus.al) begin
            link[toIdx(bus.faddr)] <= head;  // old head becomes next
        end
    end

    aFreeRange: assert property (@(posedge i_clk) disable iff (!i_arstN)
        bus.fr |-> inRange(bus.faddr));

endmodule

`default_nettype wire

/* verilog/cellRam.sv */
// cell data store, registered read, read-before-write
// the alloc write port wins over a user write to the same cell
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module cellRam (
    input  wire logic               i_clk,
    input  wire logic               i_arstN,
    cellBus.storage                 bus,
    input  wire logic               i_allocWr,
    input  wire cellPkg::cellIdx_t  i_allocIdx,
    input  wire cellPkg::cellWord_t i_allocData
);
    import cellPkg::*;

    cellWord_t mem [`CELL_COUNT];
    cellIdx_t  wIdx;
    cellIdx_t  rIdx;

    assign wIdx = toIdx(bus.waddr);
    assign rIdx = toIdx(bus.raddr);

    always_ff @(posedge i_clk) begin
        if (i_allocWr) begin
            mem[i_allocIdx] <= i_allocData;
        end
        if (bus.wr && !(i_allocWr && (i_allocIdx == wIdx))) begin
            mem[wIdx] <= bus.wdata;  // user write loses on collision
        end
    end

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            bus.rdata <= '0;
        end else if (bus.rd) begin
            bus.rdata <= mem[rIdx];  // old value on same-cycle write
        end
    end

    aUserRange: assert property (@(posedge i_clk) disable iff (!i_arstN)
        (bus.wr |-> inRange(bus.waddr)) and (bus.rd |-> inRange(bus.raddr)));

endmodule

`default_nettype wire

/* verilog/allocTop.sv */
// allocator top with self-test, free list and cell store on one cell bus
// external requests count only while o_running is low
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module allocTop (
    input  wire logic               i_clk,
    input  wire logic               i_arstN,
    input  wire logic               i_en,      // self-test enable
    output logic                    o_running,
    output logic                    o_passed,
    output logic [`DEBUG_W-1:0]     o_debug,
    input  wire logic               i_al,
    input  wire cellPkg::cellWord_t i_adata,
    output cellPkg::cellAddr_t      o_aaddr,
    input  wire logic               i_fr,
    input  wire cellPkg::cellAddr_t i_faddr,
    input  wire logic               i_wr,
    input  wire cellPkg::cellAddr_t i_waddr,
    input  wire cellPkg::cellWord_t i_wdata,
    input  wire logic               i_rd,
    input  wire cellPkg::cellAddr_t i_raddr,
    output cellPkg::cellWord_t      o_rdata
);
    import cellPkg::*;
    import testPkg::*;

    cellBus     bus ();
    logic       allocWr;    // free list to store
    cellIdx_t   allocIdx;
    cellWord_t  allocData;
    testDebug_t debugRec;

    assign o_debug = debugRec;
    assign o_aaddr = bus.aaddr;
    assign o_rdata = bus.rdata;

    allocSelfTest uSelfTest (
        .i_clk     (i_clk),
        .i_arstN   (i_arstN),
        .i_en      (i_en),
        .i_al      (i_al),
        .i_adata   (i_adata),
        .i_fr      (i_fr),
        .i_faddr   (i_faddr),
        .i_wr      (i_wr),
        .i_waddr   (i_waddr),
        .i_wdata   (i_wdata),
        .i_rd      (i_rd),
        .i_raddr   (i_raddr),
        .o_running (o_running),
        .o_passed  (o_passed),
        .o_debug   (debugRec),
        .bus       (bus.requester)
    );

    allocFreeList uFreeList (
        .i_clk       (i_clk),
        .i_arstN     (i_arstN),
        .bus         (bus.allocator),
        .o_allocWr   (allocWr),
        .o_allocIdx  (allocIdx),
        .o_allocData (allocData)
    );

    cellRam uRam (
        .i_clk       (i_clk),
        .i_arstN     (i_arstN),
        .bus         (bus.storage),
        .i_allocWr   (allocWr),
        .i_allocIdx  (allocIdx),
        .i_allocData (allocData)
    );

endmodule

`default_nettype wire

/* dv/allocChecker.sv */
// reference model of the allocator and the cell store, compared at each falling edge
// the model takes over once the self-test stops: cells 0 to 3 live, free list empty
// only cells handed out by the stimulus are read back
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module allocChecker (
    input wire logic                i_clk, i_arstN, i_en, i_running, i_passed,
    input wire logic [`DEBUG_W-1:0] i_debug,
    input wire logic                i_al, i_fr, i_wr, i_rd,
    input wire cellPkg::cellWord_t  i_adata, i_wdata, i_rdata,
    input wire cellPkg::cellAddr_t  i_aaddr, i_faddr, i_waddr, i_raddr
);
    import cellPkg::*;

    cellAddr_t freeStack [$];       // top at the back
    cellWord_t mem [cellAddr_t];    // keyed by cell address
    int        freshCnt;            // next never-used cell
    bit        selfDone;            // script finished, model live
    bit        aValid;              // alloc response pending or held
    bit        rValid;
    cellAddr_t expA;
    cellWord_t expR;
    string     aTest;               // test owning the last alloc
    int        errCount = 0;

    task automatic compareValue(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
        if (expVal !== actVal) begin
            errCount++;
            $display("mismatch %s: expected %0h, actual %0h at %0t", name, expVal, actVal,
                     $time);
        end
    endtask

    task automatic resetModel();
        freeStack.delete();
        mem.delete();
        freshCnt = 4;               // 16'h5000 to 16'h5003 used by the script
        selfDone = 1'b0;
        aValid   = 1'b0;
        rValid   = 1'b0;
    endtask

    task automatic applyRequests();
        cellAddr_t grant;
        cellWord_t oldRd;
        grant = 16'h0000;
        oldRd = i_rd ? mem[i_raddr] : 16'h0000;  // value before this cycle's writes
        if (i_al) begin
            aTest = "lifoReuse";
            if (i_fr) begin
                grant = i_faddr;                  // freed cell handed straight over
            end else if (freeStack.size() > 0) begin
                grant = freeStack.pop_back();
            end else if (freshCnt < `CELL_COUNT) begin
                grant = `CELL_BASE + freshCnt[15:0];
                aTest = "freshAlloc";
                freshCnt++;
            end else begin
                aTest = "exhaustion";             // every cell live, store untouched
            end
            if (grant != 16'h0000) begin
                mem[grant] = i_adata;
            end
            expA   = grant;
            aValid = 1'b1;
        end else if (i_fr) begin
            freeStack.push_back(i_faddr);
        end
        if (i_wr && !(i_al && grant == i_waddr)) begin
            mem[i_waddr] = i_wdata;               // alloc write wins a collision
        end
        if (i_rd) begin
            expR   = oldRd;
            rValid = 1'b1;
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_arstN) begin
            resetModel();
        end else begin
            if (!selfDone && !i_en) begin
                compareValue("pause", 64'd0, 64'(i_running));
            end
            if (!selfDone && i_en && !i_running) begin
                compareValue("selfTest", 64'd1, 64'(i_passed));
                compareValue("selfTest", 64'd0, i_debug);
                selfDone = 1'b1;
            end
            if (selfDone) begin
                if (aValid) begin
                    compareValue(aTest, 64'(expA), 64'(i_aaddr));  // held until next alloc
                end
                if (rValid) begin
                    compareValue("dataPath", 64'(expR), 64'(i_rdata));
                end
                applyRequests();
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_allocTop.sv */
// drives the allocator: self-test with random pauses, then random cell traffic
// request ports stay idle until the self-test has stopped
`timescale 1ns/1ps
`default_nettype none
`include "alloc_config.svh"

module tb_allocTop;
    localparam int PERIOD   = 20;
    localparam int SELF_MAX = 40;   // enabled cycles allowed for the script
    localparam int RAND_CYC = 400;

    logic                clk, arstN, en, running, passed;
    logic                al, fr, wr, rd;
    logic [`DEBUG_W-1:0] debugRec;
    logic [15:0]         adata, aaddr, faddr, waddr, wdata, raddr, rdata;
    logic [31:0]         lcgState;
    logic [15:0]         live [$];  // cells the stimulus owns
    int                  errCount;  // failures outside the checker
    bit                  finished;

    allocTop DUT (
        .i_clk(clk), .i_arstN(arstN), .i_en(en), .o_running(running), .o_passed(passed),
        .o_debug(debugRec), .i_al(al), .i_adata(adata), .o_aaddr(aaddr), .i_fr(fr),
        .i_faddr(faddr), .i_wr(wr), .i_waddr(waddr), .i_wdata(wdata), .i_rd(rd),
        .i_raddr(raddr), .o_rdata(rdata)
    );

    allocChecker chk (
        .i_clk(clk), .i_arstN(arstN), .i_en(en), .i_running(running), .i_passed(passed),
        .i_debug(debugRec), .i_al(al), .i_adata(adata), .i_aaddr(aaddr), .i_fr(fr),
        .i_faddr(faddr), .i_wr(wr), .i_waddr(waddr), .i_wdata(wdata), .i_rd(rd),
        .i_raddr(raddr), .i_rdata(rdata)
    );

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];     // upper half, low bits cycle too fast
    endfunction

    function automatic logic [15:0] pickLive();
        return live[nextRand() % live.size()];
    endfunction

    task automatic runSelfTest(output bit done);
        int          enCycles;
        int          pauseLeft;
        int          len;
        logic [15:0] r;
        enCycles  = 1;
        pauseLeft = 15;             // keeps phase 1 inside the watchdog budget
        done      = 1'b0;
        en        = 1'b1;
        while (!done && enCycles <= SELF_MAX) begin
            @(posedge clk);
            #2;
            r = nextRand();
            if (!running) begin
                done = 1'b1;        // en high, so the script has stopped
            end else begin
                if (pauseLeft > 0 && r[1:0] == 2'd0) begin
                    len = 1 + int'(r[5:4]);
                    if (len > pauseLeft) begin
                        len = pauseLeft;
                    end
                    pauseLeft -= len;
                    en = 1'b0;
                    repeat (len) @(posedge clk);
                    #2;
                    en = 1'b1;
                end
                enCycles++;
            end
        end
    endtask

    task automatic driveRandomTraffic();
        int pick;
        for (int cyc = 0; cyc < RAND_CYC; cyc++) begin
            @(posedge clk);
            #2;
            if (al && aaddr != 16'h0000) begin
                live.push_back(aaddr);        // grant of the previous cycle
            end
            {al, fr, wr, rd} = '0;
            if (nextRand() % 8 != 0) begin
                al    = 1'b1;
                adata = nextRand();
            end
            if (live.size() > 0 && nextRand() % 8 == 0) begin
                pick  = nextRand() % live.size();
                faddr = live[pick];
                live.delete(pick);
                fr    = 1'b1;
            end
            if (live.size() > 0 && nextRand() % 2 == 0) begin
                rd    = 1'b1;
                raddr = pickLive();
            end
            if (live.size() > 0 && nextRand() % 4 == 0) begin
                wr    = 1'b1;
                wdata = nextRand();
                waddr = pickLive();
                if (rd && nextRand() % 4 == 0) begin
                    waddr = raddr;            // same-cell read and write
                end
            end
        end
        @(posedge clk);
        #2;
        {al, fr, wr, rd} = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((5 + SELF_MAX + RAND_CYC + 20) * PERIOD);
        $display("watchdog expired before the run finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        lcgState = 32'hf30609e9;
        errCount = 0;
        {arstN, en, al, fr, wr, rd} = '0;
        {adata, faddr, waddr, wdata, raddr} = '0;
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;
        runSelfTest(finished);
        if (finished) begin
            @(posedge clk);                   // one more enabled cycle for the checker
            #2;
            en = 1'b0;
            driveRandomTraffic();
        end else begin
            errCount++;
            $display("self-test still running after %0d enabled cycles", SELF_MAX);
            en = 1'b0;
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d in checks, %0d in sequencing", chk.errCount, errCount);
        if (chk.errCount == 0 && errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/cellPkg.sv
verilog/testPkg.sv
verilog/cellBus.sv
verilog/allocSelfTest.sv
verilog/allocFreeList.sv
verilog/cellRam.sv
verilog/allocTop.sv
dv/allocChecker.sv
dv/tb_allocTop.sv

/* run.sh */
#!/usr/bin/env bash
# build the allocator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_allocTop -f all.f

out=$(./obj_dir/Vtb_allocTop)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
